//--- hdl/user_io_config.svh
`ifndef USER_IO_CONFIG_SVH
`define USER_IO_CONFIG_SVH

// reply byte for byte 0 of every transfer
`define USER_IO_CORE_TYPE 8'hA4

// feature word sent MSB first on command 0x80
`define USER_IO_FEATURES 32'h0000_0023

`define USER_IO_NUM_JOY 5
`define USER_IO_STATUS_W 64

// host command codes
`define CMD_CTRL 8'h01
`define CMD_KEY 8'h05
`define CMD_CONF_STR 8'h14
`define CMD_STATUS8 8'h15
`define CMD_STATUS64 8'h1E
`define CMD_CORE_MOD 8'h21
`define CMD_JOY_BASE 8'h60
`define CMD_FEATURES 8'h80

`endif

//--- hdl/user_io_pkg.sv
`default_nettype none

package user_io_pkg;

	// one completed byte plus its framing context
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
		logic [7:0] cmd;
		logic [9:0] index;
	} spi_byte_t;

	// buttons, switches and video flags from the LSB up
	typedef struct packed {
		logic       spare;
		logic       no_csync;
		logic       ypbpr;
		logic       scandoubler_disable;
		logic [1:0] switches;
		logic [1:0] buttons;
	} ctrl_fields_t;

	// written raw by the host, read back as fields
	typedef union packed {
		logic [7:0]   raw;
		ctrl_fields_t fields;
	} ctrl_byte_u;

	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_t;

	typedef logic [31:0] joy_word_t;

endpackage

`default_nettype wire

//--- hdl/spi_frame.sv
`timescale 1ns/10ps
`default_nettype none

`include "user_io_config.svh"

module spi_frame import user_io_pkg::*; (
	input  wire logic       spi_sck,
	input  wire logic       SPI_SS_IO,
	input  wire logic       spi_mosi_i,
	input  wire logic [7:0] reply_next_i,
	output spi_byte_t       rx_byte_o,
	output logic      [9:0] conf_addr_o,
	output logic            spi_miso_o
);

	logic [2:0] bit_cnt;
	logic [9:0] byte_cnt;
	logic [6:0] sbuf;
	logic [7:0] cmd_q;
	logic [7:0] tx_byte;
	logic       tx_lsb;
	logic [7:0] rx_data;
	logic       byte_done;
	logic [2:0] tx_sel;

	// live MOSI bit completes the byte
	assign rx_data = {sbuf, spi_mosi_i};
	assign byte_done = (bit_cnt == 3'd7);

	// bit 7 goes out after the first rising edge of a byte
	assign tx_sel = ~(bit_cnt - 3'd1);

	always_ff @(posedge spi_sck) begin
		sbuf <= {sbuf[5:0], spi_mosi_i};
	end

	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt <= 3'd0;
			byte_cnt <= 10'd0;
			cmd_q <= 8'h00;
			tx_byte <= `USER_IO_CORE_TYPE;
			tx_lsb <= 1'b0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (byte_done) begin
				if (~&byte_cnt)
					byte_cnt <= byte_cnt + 10'd1;
				if (byte_cnt == 10'd0)
					cmd_q <= rx_data;
				tx_byte <= reply_next_i;
				// last bit of the outgoing byte is still owed
				tx_lsb <= tx_byte[0];
			end
		end
	end

	always_ff @(negedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			spi_miso_o <= 1'b0;
		else if (bit_cnt == 3'd0)
			spi_miso_o <= tx_lsb;
		else
			spi_miso_o <= tx_byte[tx_sel];
	end

	assign rx_byte_o = '{valid: byte_done,
		data: rx_data,
		cmd: (byte_cnt == 10'd0) ? rx_data : cmd_q,
		index: byte_cnt};

	assign conf_addr_o = byte_cnt;

endmodule

`default_nettype wire

//--- hdl/host_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "user_io_config.svh"

module host_regs import user_io_pkg::*; (
	input  wire logic                      spi_sck,
	input  wire spi_byte_t                 rx_byte_i,
	output ctrl_fields_t                   ctrl_o,
	output joy_word_t                      joystick_o [`USER_IO_NUM_JOY],
	output logic [`USER_IO_STATUS_W-1:0]   status_o,
	output logic [6:0]                     core_mod_o
);

	ctrl_byte_u ctrl_q;
	logic       arg_byte;
	logic [2:0] byte_sel;

	// any byte after the command
	assign arg_byte = rx_byte_i.valid && (rx_byte_i.index != 10'd0);

	// argument bytes are numbered from 1, LSB first
	assign byte_sel = rx_byte_i.index[2:0] - 3'd1;

	always_ff @(posedge spi_sck) begin
		if (arg_byte) begin
			case (rx_byte_i.cmd)
				`CMD_CTRL: begin
					if (rx_byte_i.index == 10'd1)
						ctrl_q.raw <= rx_byte_i.data;
				end
				`CMD_STATUS64: begin
					if (rx_byte_i.index <= 10'd8)
						status_o[{byte_sel, 3'b000} +: 8] <= rx_byte_i.data;
				end
				`CMD_STATUS8: begin
					if (rx_byte_i.index == 10'd1)
						status_o <= {{(`USER_IO_STATUS_W - 8){1'b0}}, rx_byte_i.data};
				end
				`CMD_CORE_MOD: begin
					if (rx_byte_i.index == 10'd1)
						core_mod_o <= rx_byte_i.data[6:0];
				end
				default: begin
					// joystick n sits at CMD_JOY_BASE + n
					for (int j = 0; j < `USER_IO_NUM_JOY; j++) begin
						if (rx_byte_i.cmd == 8'(`CMD_JOY_BASE + j) &&
								rx_byte_i.index <= 10'd4)
							joystick_o[j][{byte_sel[1:0], 3'b000} +: 8] <= rx_byte_i.data;
					end
				end
			endcase
		end
	end

	assign ctrl_o = ctrl_q.fields;

endmodule

`default_nettype wire

//--- hdl/key_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "user_io_config.svh"

module key_decoder import user_io_pkg::*; (
	input  wire logic      spi_sck,
	input  wire logic      SPI_SS_IO,
	input  wire spi_byte_t rx_byte_i,
	output key_event_t     key_o
);

	logic       ext_q;
	logic       pressed_q;
	logic       strobe_q;
	logic       evt_pressed;
	logic       evt_ext;
	logic [7:0] evt_code;
	logic       key_byte;
	logic       is_prefix;
	logic       ext_cur;
	logic       pressed_cur;

	assign key_byte = rx_byte_i.valid && (rx_byte_i.cmd == `CMD_KEY) &&
		(rx_byte_i.index != 10'd0);
	assign is_prefix = (rx_byte_i.data == 8'hE0) || (rx_byte_i.data == 8'hF0);

	// pending flags start fresh at the first argument byte
	assign ext_cur = (rx_byte_i.index == 10'd1) ? 1'b0 : ext_q;
	assign pressed_cur = (rx_byte_i.index == 10'd1) ? 1'b1 : pressed_q;

	always_ff @(posedge spi_sck) begin
		if (key_byte) begin
			ext_q <= (rx_byte_i.data == 8'hE0) ? 1'b1 : ext_cur;
			pressed_q <= (rx_byte_i.data == 8'hF0) ? 1'b0 : pressed_cur;
			if (!is_prefix) begin
				evt_code <= rx_byte_i.data;
				evt_pressed <= pressed_cur;
				evt_ext <= ext_cur;
			end
		end
	end

	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			strobe_q <= 1'b0;
		else
			strobe_q <= key_byte && !is_prefix;
	end

	assign key_o = '{strobe: strobe_q, pressed: evt_pressed, extended: evt_ext,
		code: evt_code};

endmodule

`default_nettype wire

//--- hdl/reply_mux.sv
`timescale 1ns/10ps
`default_nettype none

`include "user_io_config.svh"

module reply_mux import user_io_pkg::*; (
	input  wire spi_byte_t  rx_byte_i,
	input  wire logic [7:0] conf_chr_i,
	output logic      [7:0] reply_next_o
);

	// picks what goes out in the byte after index
	always_comb begin
		reply_next_o = 8'h00;
		case (rx_byte_i.cmd)
			`CMD_CONF_STR: begin
				// ROM address follows the byte index
				reply_next_o = conf_chr_i;
			end
			`CMD_FEATURES: begin
				case (rx_byte_i.index)
					10'd0: begin
						reply_next_o = 8'h80;
					end
					10'd1: begin
						reply_next_o = 8'(`USER_IO_FEATURES >> 24);
					end
					10'd2: begin
						reply_next_o = 8'(`USER_IO_FEATURES >> 16);
					end
					10'd3: begin
						reply_next_o = 8'(`USER_IO_FEATURES >> 8);
					end
					10'd4: begin
						reply_next_o = 8'(`USER_IO_FEATURES);
					end
					default: begin
						reply_next_o = 8'h00;
					end
				endcase
			end
			default: begin
				reply_next_o = 8'h00;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/user_io.sv
`timescale 1ns/10ps
`default_nettype none

`include "user_io_config.svh"

module user_io import user_io_pkg::*; (
	input  wire logic                      spi_sck,
	input  wire logic                      SPI_SS_IO,
	input  wire logic                      spi_mosi_i,
	output logic                           spi_miso_o,
	output logic [9:0]                     conf_addr_o,
	input  wire logic [7:0]                conf_chr_i,
	output ctrl_fields_t                   ctrl_o,
	output joy_word_t                      joystick_o [`USER_IO_NUM_JOY],
	output logic [`USER_IO_STATUS_W-1:0]   status_o,
	output logic [6:0]                     core_mod_o,
	output key_event_t                     key_o
);

	spi_byte_t  rx_byte;
	logic [7:0] reply_next;

	spi_frame u_spi_frame (
		.spi_sck      (spi_sck),
		.SPI_SS_IO    (SPI_SS_IO),
		.spi_mosi_i   (spi_mosi_i),
		.reply_next_i (reply_next),
		.rx_byte_o    (rx_byte),
		.conf_addr_o  (conf_addr_o),
		.spi_miso_o   (spi_miso_o)
	);

	host_regs u_host_regs (
		.spi_sck    (spi_sck),
		.rx_byte_i  (rx_byte),
		.ctrl_o     (ctrl_o),
		.joystick_o (joystick_o),
		.status_o   (status_o),
		.core_mod_o (core_mod_o)
	);

	key_decoder u_key_decoder (
		.spi_sck   (spi_sck),
		.SPI_SS_IO (SPI_SS_IO),
		.rx_byte_i (rx_byte),
		.key_o     (key_o)
	);

	// next reply goes back to the framer
	reply_mux u_reply_mux (
		.rx_byte_i    (rx_byte),
		.conf_chr_i   (conf_chr_i),
		.reply_next_o (reply_next)
	);

endmodule

`default_nettype wire

//--- verification/user_io_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "user_io_config.svh"

module user_io_tb import user_io_pkg::*; ();

	localparam int conf_len = 12;
	localparam logic [8*conf_len-1:0] conf_text = "CORE;O1,SCAN";

	logic                         spi_sck;
	logic                         SPI_SS_IO;
	logic                         mosi;
	logic                         miso;
	logic [9:0]                   conf_addr;
	logic [7:0]                   conf_chr;
	ctrl_fields_t                 ctrl;
	joy_word_t                    joystick [`USER_IO_NUM_JOY];
	logic [`USER_IO_STATUS_W-1:0] status;
	logic [6:0]                   core_mod;
	key_event_t                   key;

	logic [7:0] tx_q [$];
	logic [7:0] rx_q [$];
	logic [9:0] exp_keys [$];
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int err_mark = 0;

	user_io u_user_io (
		.spi_sck     (spi_sck),
		.SPI_SS_IO   (SPI_SS_IO),
		.spi_mosi_i  (mosi),
		.spi_miso_o  (miso),
		.conf_addr_o (conf_addr),
		.conf_chr_i  (conf_chr),
		.ctrl_o      (ctrl),
		.joystick_o  (joystick),
		.status_o    (status),
		.core_mod_o  (core_mod),
		.key_o       (key)
	);

	// string ROM model with the first character in the top byte
	function automatic logic [7:0] conf_char(input int addr);
		if (addr < conf_len)
			return conf_text[8*(conf_len-1-addr) +: 8];
		return 8'h00;
	endfunction

	assign conf_chr = conf_char(int'(conf_addr));

	initial begin
		spi_sck = 1'b0;
		forever #2 spi_sck = ~spi_sck;
	end

	task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp,
			input string what);
		checks++;
		assert (got === exp)
		else begin
			$display("Fail %0t: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic start_cmd(input logic [7:0] cmd);
		tx_q.delete();
		tx_q.push_back(cmd);
	endtask

	// MISO lags one edge, so the last reply bit needs one extra clock
	task automatic spi_transfer;
		int nbits;
		logic [7:0] acc;
		nbits = tx_q.size() * 8;
		acc = 8'h00;
		rx_q.delete();
		@(posedge spi_sck);
		#1;
		SPI_SS_IO = 1'b0;
		for (int i = 0; i <= nbits; i++) begin
			mosi = (i < nbits) ? tx_q[i / 8][7 - i % 8] : 1'b0;
			@(posedge spi_sck);
			if (i > 0) begin
				acc = {acc[6:0], miso};
				if ((i - 1) % 8 == 7)
					rx_q.push_back(acc);
			end
			#1;
		end
		SPI_SS_IO = 1'b1;
		expect_eq(64'(rx_q[0]), 64'(`USER_IO_CORE_TYPE), "byte 0 reply");
		repeat (2) @(posedge spi_sck);
	endtask

	// E0 and F0 prefix rule with flags carried through the transfer
	task automatic predict_keys;
		logic ext;
		logic pressed;
		ext = 1'b0;
		pressed = 1'b1;
		for (int i = 1; i < tx_q.size(); i++) begin
			if (tx_q[i] == 8'hE0)
				ext = 1'b1;
			else if (tx_q[i] == 8'hF0)
				pressed = 1'b0;
			else
				exp_keys.push_back({pressed, ext, tx_q[i]});
		end
	endtask

	task automatic key_transfer;
		int waited;
		predict_keys();
		spi_transfer();
		waited = 0;
		while (exp_keys.size() != 0 && waited < 32) begin
			@(posedge spi_sck);
			waited++;
		end
		if (exp_keys.size() != 0) begin
			$display("Timed out waiting for %0d key events", exp_keys.size());
			errors++;
			exp_keys.delete();
		end
	endtask

	task automatic send_key_bytes(input logic [47:0] seq, input int len);
		start_cmd(`CMD_KEY);
		for (int k = 0; k < len; k++)
			tx_q.push_back(seq[8*(len-1-k) +: 8]);
		key_transfer();
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %s finished with %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	always @(posedge spi_sck) begin : key_monitor
		logic [9:0] got;
		if (key.strobe) begin
			got = {key.pressed, key.extended, key.code};
			assert (exp_keys.size() != 0)
			else begin
				$display("Key event %0h arrived while none was expected", got);
				errors++;
			end
			if (exp_keys.size() != 0)
				expect_eq(64'(got), 64'(exp_keys.pop_front()), "key event");
		end
	end

	initial begin
		logic [7:0] b;
		logic [63:0] s;
		logic [31:0] feat;
		joy_word_t joy_exp [`USER_IO_NUM_JOY];
		int n;
		void'($urandom(48400));
		SPI_SS_IO = 1'b1;
		mosi = 1'b0;
		feat = `USER_IO_FEATURES;
		repeat (16) @(posedge spi_sck);
		expect_eq(64'(key.strobe), 64'd0, "key strobe after reset");

		for (int r = 0; r < 4; r++) begin
			b = 8'($urandom);
			start_cmd(`CMD_CTRL);
			tx_q.push_back(b);
			spi_transfer();
			expect_eq(64'(ctrl.buttons), 64'(b[1:0]), "ctrl buttons");
			expect_eq(64'(ctrl.switches), 64'(b[3:2]), "ctrl switches");
			expect_eq(64'(ctrl.scandoubler_disable), 64'(b[4]), "ctrl scandoubler_disable");
			expect_eq(64'(ctrl.ypbpr), 64'(b[5]), "ctrl ypbpr");
			expect_eq(64'(ctrl.no_csync), 64'(b[6]), "ctrl no_csync");
			expect_eq(64'(ctrl.spare), 64'(b[7]), "ctrl spare");
			b = 8'($urandom);
			start_cmd(`CMD_CORE_MOD);
			tx_q.push_back(b);
			spi_transfer();
			expect_eq(64'(core_mod), 64'(b[6:0]), "core mode");
		end
		finish_test("ctrl");

		for (n = 0; n < `USER_IO_NUM_JOY; n++) begin
			joy_exp[n] = $urandom;
			start_cmd(8'(`CMD_JOY_BASE + n));
			for (int k = 0; k < 4; k++)
				tx_q.push_back(joy_exp[n][8*k +: 8]);
			// trailing bytes must be ignored
			tx_q.push_back(8'($urandom));
			tx_q.push_back(8'($urandom));
			spi_transfer();
			for (int j = 0; j <= n; j++)
				expect_eq(64'(joystick[j]), 64'(joy_exp[j]), "joystick word");
		end
		s = {$urandom, $urandom};
		start_cmd(`CMD_STATUS64);
		for (int k = 0; k < 8; k++)
			tx_q.push_back(s[8*k +: 8]);
		tx_q.push_back(8'($urandom));
		spi_transfer();
		expect_eq(status, s, "status word");
		b = 8'($urandom);
		start_cmd(`CMD_STATUS8);
		tx_q.push_back(b);
		tx_q.push_back(8'($urandom));
		spi_transfer();
		expect_eq(status, {56'd0, b}, "status byte");
		finish_test("regs");

		send_key_bytes(48'hE075, 2);
		send_key_bytes(48'hF01C, 2);
		send_key_bytes(48'hE0F06B, 3);
		send_key_bytes(48'h1C3221F02A, 5);
		for (int r = 0; r < 10; r++) begin
			start_cmd(`CMD_KEY);
			n = $urandom_range(1, 6);
			for (int k = 0; k < n; k++) begin
				case ($urandom_range(0, 3))
					0: tx_q.push_back(8'hE0);
					1: tx_q.push_back(8'hF0);
					default: tx_q.push_back(8'($urandom_range(1, 127)));
				endcase
			end
			key_transfer();
		end
		finish_test("keys");

		start_cmd(`CMD_CONF_STR);
		repeat (conf_len + 2) tx_q.push_back(8'h00);
		spi_transfer();
		for (int k = 0; k < conf_len + 2; k++)
			expect_eq(64'(rx_q[k + 1]), 64'(conf_char(k)), "config string char");
		start_cmd(`CMD_FEATURES);
		repeat (6) tx_q.push_back(8'h00);
		spi_transfer();
		expect_eq(64'(rx_q[1]), 64'h80, "feature command echo");
		for (int k = 0; k < 4; k++)
			expect_eq(64'(rx_q[k + 2]), 64'(feat[31 - 8*k -: 8]), "feature byte");
		expect_eq(64'(rx_q[6]), 64'd0, "byte after features");
		start_cmd(8'h42);
		repeat (3) tx_q.push_back(8'($urandom));
		spi_transfer();
		for (int k = 1; k < 4; k++)
			expect_eq(64'(rx_q[k]), 64'd0, "unused command reply");
		finish_test("reads");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+hdl
hdl/user_io_pkg.sv
hdl/spi_frame.sv
hdl/host_regs.sv
hdl/key_decoder.sv
hdl/reply_mux.sv
hdl/user_io.sv
verification/user_io_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/10ps --top-module user_io_tb \
		-Mdir obj_dir -f build.f; then
	echo "verilator build failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/Vuser_io_tb); then
	echo "$sim_out"
	echo "simulation exited with an error status"
	exit 1
fi
echo "$sim_out"

if grep -qxF "=== PASS ===" <<< "$sim_out"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
